// ==== mem_cmd_router.sv ====
// Command router between the command slot and the DRAM and host targets
// Keeps at most one request outstanding and merges the responses
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_cmd_router
  import mem_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,

  input  logic      cmd_v_i,
  input  mem_cmd_s  cmd_i,
  output logic      cmd_yumi_o,

  output logic      resp_v_o,
  output mem_resp_s resp_o,
  input  logic      resp_ready_i,

  mem_tgt_if.router dram,
  mem_tgt_if.router host
);

  logic outstanding_r;
  logic host_sel;
  logic resp_done;

  // Address decode, everything under the DRAM base is host MMIO
  assign host_sel = (cmd_i.addr < `MEM_DRAM_BASE);

  assign dram.cmd = cmd_i;
  assign host.cmd = cmd_i;

  assign dram.cmd_v = cmd_v_i & ~host_sel & ~outstanding_r;
  assign host.cmd_v = cmd_v_i & host_sel & ~outstanding_r;

  assign cmd_yumi_o = host_sel ? host.cmd_yumi : dram.cmd_yumi;

  // Only one target can answer, host wins the mux when valid
  assign resp_o   = host.resp_v ? host.resp : dram.resp;
  assign resp_v_o = host.resp_v | dram.resp_v;

  assign dram.resp_ready = resp_ready_i;
  assign host.resp_ready = resp_ready_i;

  assign resp_done = resp_v_o & resp_ready_i;

  // Set on hand-off to a target, cleared once the response slot takes it
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      outstanding_r <= 1'b0;
    else if (cmd_yumi_o)
      outstanding_r <= 1'b1;
    else if (resp_done)
      outstanding_r <= 1'b0;
  end

endmodule

// ==== mem_defs.svh ====
// Memory subsystem widths, DRAM geometry and host register map
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

`define MEM_ADDR_W 32
`define MEM_DATA_W 32

// DRAM window starts here, anything below goes to the host
`define MEM_DRAM_BASE 32'h8000_0000
`define MEM_DRAM_WORDS 64
`define MEM_DRAM_LATENCY 4

// Host MMIO registers
`define MEM_HOST_SCRATCH_ADDR 32'h0010_0000
`define MEM_HOST_FINISH_ADDR 32'h0010_0004

`endif

// ==== mem_dram_model.sv ====
// DRAM model, a word array answering after a fixed latency
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_dram_model
  import mem_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  mem_tgt_if.target tgt
);

  localparam int IDX_W = $clog2(`MEM_DRAM_WORDS);
  localparam int CNT_W = $clog2(`MEM_DRAM_LATENCY + 1);

  logic [`MEM_DATA_W-1:0]     mem [`MEM_DRAM_WORDS];
  logic [`MEM_DRAM_WORDS-1:0] written_r;
  logic [`MEM_ADDR_W-1:0]     offset;
  logic [IDX_W-1:0]           idx;
  logic                       take;
  logic                       busy_r;
  logic [CNT_W-1:0]           count_r;
  mem_resp_s                  resp_r;

  // Word index, wraps around the array
  assign offset = tgt.cmd.addr - `MEM_DRAM_BASE;
  assign idx    = offset[IDX_W+1:2];

  assign take         = tgt.cmd_v & ~busy_r;
  assign tgt.cmd_yumi = take;

  assign tgt.resp   = resp_r;
  assign tgt.resp_v = busy_r & (count_r == '0);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      busy_r  <= 1'b0;
      count_r <= '0;
    end
    else if (take)
    begin
      busy_r  <= 1'b1;
      count_r <= CNT_W'(`MEM_DRAM_LATENCY - 1);
    end
    else if (tgt.resp_v & tgt.resp_ready)
      busy_r <= 1'b0;
    else if (count_r != '0)
      count_r <= count_r - CNT_W'(1);
  end

  // Unwritten words read back as zero
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      written_r <= '0;
    else if (take && tgt.cmd.op == MEM_STORE)
      written_r[idx] <= 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (take)
    begin
      if (tgt.cmd.op == MEM_STORE)
        mem[idx] <= tgt.cmd.data;
      resp_r.op   <= tgt.cmd.op;
      resp_r.data <= (tgt.cmd.op == MEM_LOAD && written_r[idx]) ? mem[idx] : '0;
    end
  end

endmodule

// ==== mem_host_mmio.sv ====
// Host MMIO block with scratch and finish registers
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_host_mmio
  import mem_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  mem_tgt_if.target tgt,
  output logic      program_finish_o
);

  logic                   take;
  logic                   resp_v_r;
  logic [`MEM_DATA_W-1:0] scratch_r;
  logic                   finish_r;
  logic [`MEM_DATA_W-1:0] rd_data;
  logic                   is_store;
  mem_resp_s              resp_r;

  assign take         = tgt.cmd_v & ~resp_v_r;
  assign tgt.cmd_yumi = take;
  assign is_store     = (tgt.cmd.op == MEM_STORE);

  assign tgt.resp         = resp_r;
  assign tgt.resp_v       = resp_v_r;
  assign program_finish_o = finish_r;

  // Unmapped addresses read zero
  always_comb
  begin
    case (tgt.cmd.addr)
      `MEM_HOST_SCRATCH_ADDR: rd_data = scratch_r;
      `MEM_HOST_FINISH_ADDR:  rd_data = `MEM_DATA_W'(finish_r);
      default:                rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      resp_v_r  <= 1'b0;
      scratch_r <= '0;
      finish_r  <= 1'b0;
    end
    else if (take)
    begin
      resp_v_r <= 1'b1;
      if (is_store && tgt.cmd.addr == `MEM_HOST_SCRATCH_ADDR)
        scratch_r <= tgt.cmd.data;
      // Sticky until reset
      if (is_store && tgt.cmd.addr == `MEM_HOST_FINISH_ADDR && tgt.cmd.data[0])
        finish_r <= 1'b1;
    end
    else if (resp_v_r & tgt.resp_ready)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (take)
    begin
      resp_r.op   <= tgt.cmd.op;
      resp_r.data <= is_store ? '0 : rd_data;
    end
  end

endmodule

// ==== mem_if.sv ====
// Router to target channel
// Valid/yumi on the command side, valid/ready on the response side
`timescale 1ns/1ps

interface mem_tgt_if
  import mem_pkg::*;
();

  mem_cmd_s  cmd;
  logic      cmd_v;
  logic      cmd_yumi;

  mem_resp_s resp;
  logic      resp_v;
  logic      resp_ready;

  modport router (
    output cmd, cmd_v, resp_ready,
    input  cmd_yumi, resp, resp_v
  );

  modport target (
    input  cmd, cmd_v, resp_ready,
    output cmd_yumi, resp, resp_v
  );

endinterface

// ==== mem_input.txt ====
// Columns: op (0 load, 1 store), addr, data, expected response data, burst
// burst 1 issues the line while resp_ready_i is held low; op f ends the list
0 80000010 00000000 00000000 0 // unwritten DRAM word
1 80000010 cafef00d 00000000 0
0 80000010 00000000 cafef00d 0
1 80000104 12345678 00000000 0 // wraps onto word 1
0 80000004 00000000 12345678 0
0 8000003c 00000000 00000000 0
1 00100000 a5a55a5a 00000000 0
0 00100000 00000000 a5a55a5a 0
0 00100008 00000000 00000000 0 // unmapped host address
0 00000000 00000000 00000000 0
0 00100004 00000000 00000000 0
1 80000020 0badbeef 00000000 0
1 00100000 11112222 00000000 1
0 80000020 00000000 0badbeef 1
0 00100000 00000000 11112222 1
1 00100004 00000001 00000000 0 // finish
0 00100004 00000000 00000001 0
f 00000000 00000000 00000000 0

// ==== mem_pkg.sv ====
// Memory subsystem types
// Command and response formats shared by the router and its targets
`include "mem_defs.svh"

package mem_pkg;

  typedef enum logic
  {
    MEM_LOAD  = 1'b0,
    MEM_STORE = 1'b1
  } mem_op_e;

  typedef struct packed
  {
    mem_op_e                op;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_DATA_W-1:0] data;
  } mem_cmd_s;

  // Store responses carry zero data
  typedef struct packed
  {
    mem_op_e                op;
    logic [`MEM_DATA_W-1:0] data;
  } mem_resp_s;

endpackage

// ==== mem_slot_reg.sv ====
// One-entry holding register, payload type set by parameter
`timescale 1ns/1ps

module mem_slot_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     in_v_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  output logic     out_v_o,
  output payload_t out_data_o,
  input  logic     out_ready_i
);

  logic     full_r;
  payload_t data_r;

  // Accepts only while empty, so load and drain never overlap
  assign in_ready_o = ~full_r;
  assign out_v_o    = full_r;
  assign out_data_o = data_r;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      full_r <= 1'b0;
    else if (in_v_i & ~full_r)
      full_r <= 1'b1;
    else if (full_r & out_ready_i)
      full_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (in_v_i & ~full_r)
      data_r <= in_data_i;
  end

endmodule

// ==== mem_subsys_props.sv ====
// Router protocol assertions, bound into mem_cmd_router
`timescale 1ns/1ps

module mem_subsys_props
  import mem_pkg::*;
(
  input logic      clk_i,
  input logic      rst_n_i,
  input logic      dram_cmd_v_i,
  input logic      dram_cmd_yumi_i,
  input logic      host_cmd_v_i,
  input logic      host_cmd_yumi_i,
  input logic      resp_v_i,
  input logic      resp_ready_i,
  input mem_resp_s resp_i
);

  logic pending_r;

  // Request in flight, tracked from the target handshakes
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      pending_r <= 1'b0;
    else if ((dram_cmd_v_i && dram_cmd_yumi_i) || (host_cmd_v_i && host_cmd_yumi_i))
      pending_r <= 1'b1;
    else if (resp_v_i && resp_ready_i)
      pending_r <= 1'b0;
  end

  // At most one target addressed per cycle
  a_one_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(dram_cmd_v_i && host_cmd_v_i))
    else $error("DRAM and host cmd_v high in the same cycle");

  a_no_cmd_outstanding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pending_r |-> !(dram_cmd_v_i || host_cmd_v_i))
    else $error("cmd_v raised while a request is outstanding");

  // Response waits unchanged for the response slot
  a_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_v_i && !resp_ready_i |=> resp_v_i && $stable(resp_i))
    else $error("router response changed before ready");

endmodule

bind mem_cmd_router mem_subsys_props props (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .dram_cmd_v_i    (dram.cmd_v),
  .dram_cmd_yumi_i (dram.cmd_yumi),
  .host_cmd_v_i    (host.cmd_v),
  .host_cmd_yumi_i (host.cmd_yumi),
  .resp_v_i        (resp_v_o),
  .resp_ready_i    (resp_ready_i),
  .resp_i          (resp_o)
);

// ==== mem_subsys_top.sv ====
// Memory command subsystem top
// Command slot, router, DRAM and host targets, response slot
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_subsys_top
  import mem_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  input  logic                   cmd_v_i,
  input  mem_op_e                cmd_op_i,
  input  logic [`MEM_ADDR_W-1:0] cmd_addr_i,
  input  logic [`MEM_DATA_W-1:0] cmd_data_i,
  output logic                   cmd_yumi_o,

  output logic                   resp_v_o,
  output mem_op_e                resp_op_o,
  output logic [`MEM_DATA_W-1:0] resp_data_o,
  input  logic                   resp_ready_i,

  output logic                   program_finish_o
);

  mem_cmd_s  cmd_in;
  mem_cmd_s  cmd_q;
  logic      cmd_q_v;
  logic      cmd_q_yumi;
  mem_resp_s rtr_resp;
  logic      rtr_resp_v;
  logic      rtr_resp_ready;
  mem_resp_s resp_q;

  assign cmd_in      = '{op: cmd_op_i, addr: cmd_addr_i, data: cmd_data_i};
  assign resp_op_o   = resp_q.op;
  assign resp_data_o = resp_q.data;

  mem_tgt_if dram_if ();
  mem_tgt_if host_if ();

  mem_slot_reg #(.payload_t(mem_cmd_s)) cmd_slot (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_v_i      (cmd_v_i),
    .in_data_i   (cmd_in),
    .in_ready_o  (cmd_yumi_o),
    .out_v_o     (cmd_q_v),
    .out_data_o  (cmd_q),
    .out_ready_i (cmd_q_yumi)
  );

  mem_cmd_router router (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cmd_v_i      (cmd_q_v),
    .cmd_i        (cmd_q),
    .cmd_yumi_o   (cmd_q_yumi),
    .resp_v_o     (rtr_resp_v),
    .resp_o       (rtr_resp),
    .resp_ready_i (rtr_resp_ready),
    .dram         (dram_if),
    .host         (host_if)
  );

  mem_dram_model dram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .tgt     (dram_if)
  );

  mem_host_mmio host (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .tgt              (host_if),
    .program_finish_o (program_finish_o)
  );

  mem_slot_reg #(.payload_t(mem_resp_s)) resp_slot (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_v_i      (rtr_resp_v),
    .in_data_i   (rtr_resp),
    .in_ready_o  (rtr_resp_ready),
    .out_v_o     (resp_v_o),
    .out_data_o  (resp_q),
    .out_ready_i (resp_ready_i)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; the exit status gives pass or fail
cd "$(dirname "$0")" &&
  verilator --binary --assert --timescale 1ns/1ps --top-module tb_mem_subsys -f src.f &&
  ./obj_dir/Vtb_mem_subsys || exit 1

// ==== src.f ====
+incdir+.
mem_pkg.sv
mem_if.sv
mem_slot_reg.sv
mem_cmd_router.sv
mem_dram_model.sv
mem_host_mmio.sv
mem_subsys_top.sv
mem_subsys_props.sv
tb_mem_subsys.sv

// ==== tb_mem_subsys.sv ====
// Testbench for the memory command subsystem
// Replays mem_input.txt with LFSR driven response back-pressure
`timescale 1ns/1ps
`include "mem_defs.svh"

module tb_mem_subsys
  import mem_pkg::*;
();

  localparam int COLS       = 5;
  localparam int STIM_WORDS = 256;
  localparam int MAX_LINES  = STIM_WORDS / COLS;
  localparam int TIMEOUT    = 100;
  localparam int HOLD_CYC   = 8;

  logic                   clk;
  logic                   rst_n;
  logic                   cmd_v;
  mem_op_e                cmd_op;
  logic [`MEM_ADDR_W-1:0] cmd_addr;
  logic [`MEM_DATA_W-1:0] cmd_data;
  logic                   cmd_yumi;
  logic                   resp_v;
  mem_op_e                resp_op;
  logic [`MEM_DATA_W-1:0] resp_data;
  logic                   resp_ready;
  logic                   program_finish;

  // Five words per line: op, addr, data, expected data, burst flag
  logic [31:0] stim [STIM_WORDS];
  logic [15:0] lfsr;
  logic        finish_exp;

  mem_subsys_top UUT (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .cmd_v_i          (cmd_v),
    .cmd_op_i         (cmd_op),
    .cmd_addr_i       (cmd_addr),
    .cmd_data_i       (cmd_data),
    .cmd_yumi_o       (cmd_yumi),
    .resp_v_o         (resp_v),
    .resp_op_o        (resp_op),
    .resp_data_o      (resp_data),
    .resp_ready_i     (resp_ready),
    .program_finish_o (program_finish)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] field(input int line, input int col);
    logic [7:0] k;
    k     = 8'(line * COLS + col);
    field = stim[k];
  endfunction

  task automatic stop_run;
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  // Called on a falling edge, returns on the falling edge after acceptance
  task automatic send_cmd(input int line);
    int waited;
    waited = 0;
    while (!cmd_yumi)
    begin
      waited++;
      if (waited > TIMEOUT)
      begin
        $display("Timeout: command on line %0d was never accepted", line);
        stop_run();
      end
      @(negedge clk);
    end
    cmd_v    = 1'b1;
    cmd_op   = (field(line, 0) == 32'd1) ? MEM_STORE : MEM_LOAD;
    cmd_addr = field(line, 1);
    cmd_data = field(line, 2);
    @(negedge clk);
    cmd_v = 1'b0;
  endtask

  // Waits for one response, checks it every cycle until the handshake
  task automatic take_resp(input int line, input bit lat_chk, input bit rand_rdy);
    int          lat;
    bit          seen;
    bit          done;
    logic [31:0] exp_lat;
    lat     = 1;
    seen    = 1'b0;
    done    = 1'b0;
    exp_lat = (field(line, 1) < `MEM_DRAM_BASE) ? 32'd3 : 32'd6;
    while (!done)
    begin
      if (lat > TIMEOUT)
      begin
        $display("Timeout: no response handshake for line %0d", line);
        stop_run();
      end
      if (seen)
        check_value("resp_v_o while waiting", 32'(resp_v), 32'd1);
      if (resp_v)
      begin
        if (!seen && lat_chk)
          check_value("response latency", 32'(lat), exp_lat);
        seen = 1'b1;
        check_value("resp_op_o", 32'(resp_op), field(line, 0));
        check_value("resp_data_o", resp_data, field(line, 3));
      end
      if (rand_rdy)
      begin
        lfsr       = lfsr_next(lfsr);
        resp_ready = lfsr[0];
      end
      else
        resp_ready = 1'b1;
      done = resp_v & resp_ready;
      @(negedge clk);
      lat++;
    end
    // Exactly one response per command
    check_value("resp_v_o after handshake", 32'(resp_v), 32'd0);
  endtask

  task automatic note_finish(input int line);
    if (field(line, 0) == 32'd1 && field(line, 1) == `MEM_HOST_FINISH_ADDR &&
        (field(line, 2) & 32'd1) != 32'd0)
      finish_exp = 1'b1;
    check_value("program_finish_o", 32'(program_finish), 32'(finish_exp));
  endtask

  initial
  begin
    int line;
    int first;
    int n;
    int idx;
    rst_n      = 1'b0;
    cmd_v      = 1'b0;
    cmd_op     = MEM_LOAD;
    cmd_addr   = '0;
    cmd_data   = '0;
    resp_ready = 1'b0;
    lfsr       = 16'd50500;
    finish_exp = 1'b0;
    $readmemh("mem_input.txt", stim);
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    check_value("cmd_yumi_o after reset", 32'(cmd_yumi), 32'd1);
    check_value("resp_v_o after reset", 32'(resp_v), 32'd0);
    check_value("program_finish_o after reset", 32'(program_finish), 32'd0);
    line = 0;
    while (line < MAX_LINES && field(line, 0) != 32'hf)
    begin
      if (field(line, 4) == 32'd0)
      begin
        send_cmd(line);
        take_resp(line, 1'b1, 1'b1);
        note_finish(line);
        line++;
      end
      else
      begin
        // Hold the response port while a group of commands goes in
        resp_ready = 1'b0;
        first      = line;
        while (line < MAX_LINES && field(line, 4) != 32'd0 && field(line, 0) != 32'hf)
        begin
          send_cmd(line);
          line++;
        end
        n = line - first;
        repeat (HOLD_CYC)
        begin
          check_value("cmd_yumi_o under back-pressure", 32'(cmd_yumi),
                      (n < 3) ? 32'd1 : 32'd0);
          if (resp_v)
            check_value("held resp_data_o", resp_data, field(first, 3));
          @(negedge clk);
        end
        for (idx = first; idx < line; idx++)
        begin
          take_resp(idx, 1'b0, 1'b0);
          note_finish(idx);
        end
      end
    end
    repeat (4)
    begin
      @(negedge clk);
      check_value("program_finish_o at end", 32'(program_finish), 32'd1);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule
